// File: hdl/saturn_clk_pkg.sv
package saturn_clk_pkg;

  // phase counter width, one bus cycle is BUS_PHASES clocks
  localparam int unsigned PHASE_W = 2;
  localparam int unsigned BUS_PHASES = 4;

  // controller drives the bus
  localparam logic [PHASE_W-1:0] PH_BUS_SEND = 2'd0;

  // decoder samples, RAM executes
  localparam logic [PHASE_W-1:0] PH_BUS_RECV = 2'd1;

  // controller captures read data and closes the command
  localparam logic [PHASE_W-1:0] PH_BUS_ECMD = 2'd3;

endpackage

// File: hdl/saturn_bus_pkg.sv
package saturn_bus_pkg;

  // full address width and nibble count, sent least significant first
  localparam int unsigned ADDR_W = 20;
  localparam int unsigned ADDR_NIBBLES = 5;

  // implemented RAM address bits, upper address bits are ignored
  localparam int unsigned RAM_BITS = 10;

  // bus command codes as seen on the nibble bus
  typedef enum logic [3:0] {
    NOP         = 4'h0,
    ID          = 4'h1,
    PC_READ     = 4'h2,
    DP_READ     = 4'h3,
    PC_WRITE    = 4'h4,
    DP_WRITE    = 4'h5,
    LOAD_PC     = 4'h6,
    LOAD_DP     = 4'h7,
    CONFIGURE   = 4'h8,
    UNCONFIGURE = 4'h9,
    POLL        = 4'ha,
    SHUTDOWN    = 4'hc,
    RESET       = 4'hf
  } bus_cmd_e;

  // one bus nibble, cmd/data line low selects the command view
  typedef union packed {
    bus_cmd_e   cmd;
    logic [3:0] val;
  } bus_nibble_u;

endpackage

// File: hdl/saturn_phase_gen.sv
module saturn_phase_gen (
  input  logic i_clk,
  input  logic i_reset,
  output logic o_en_bus_send,
  output logic o_en_bus_recv,
  output logic o_en_bus_ecmd
);

  import saturn_clk_pkg::*;

  logic [PHASE_W-1:0] phase;

  // free running phase counter, starts at phase 0 after reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      phase <= '0;
    end else if (phase == PHASE_W'(BUS_PHASES - 1)) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // one clock wide enables per bus cycle
  assign o_en_bus_send = (phase == PH_BUS_SEND);
  assign o_en_bus_recv = (phase == PH_BUS_RECV);
  assign o_en_bus_ecmd = (phase == PH_BUS_ECMD);

endmodule

// File: hdl/saturn_bus_ctrl.sv
module saturn_bus_ctrl (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_en_bus_send,
  input  logic                              i_en_bus_recv,
  input  logic                              i_en_bus_ecmd,
  input  logic                              i_read_stall,
  input  logic                              i_load_pc,
  input  logic                              i_load_dp,
  input  logic                              i_read_pc,
  input  logic                              i_read_dp,
  input  logic                              i_write_dp,
  input  logic                              i_cmd_reset,
  input  logic [saturn_bus_pkg::ADDR_W-1:0] i_address,
  input  logic [3:0]                        i_nibble,
  input  logic [3:0]                        i_bus_data,
  output logic [3:0]                        o_bus_data,
  output logic                              o_bus_strobe,
  output logic                              o_bus_cmd_data,
  output logic [3:0]                        o_nibble,
  output logic                              o_rd_valid,
  output logic                              o_ack,
  output logic                              o_stalled_by_bus
);

  import saturn_bus_pkg::*;

  bus_cmd_e    last_cmd;
  bus_nibble_u bus_out;
  logic [2:0]  addr_cnt;
  logic        send_addr;
  logic        send_pc_read;
  logic        ack_pending;
  logic        rd_pending;
  logic        want_read;
  bus_cmd_e    read_cmd;

  assign o_bus_data = bus_out;
  assign want_read  = i_read_pc || i_read_dp;
  assign read_cmd   = i_read_pc ? PC_READ : DP_READ;

  always_ff @(posedge i_clk) begin
    // ack and read valid are single clock pulses
    o_ack      <= 1'b0;
    o_rd_valid <= 1'b0;
    if (i_reset) begin
      last_cmd         <= RESET;
      o_bus_strobe     <= 1'b0;
      o_bus_cmd_data   <= 1'b1;
      o_stalled_by_bus <= 1'b0;
      addr_cnt         <= '0;
      send_addr        <= 1'b0;
      send_pc_read     <= 1'b0;
      ack_pending      <= 1'b0;
      rd_pending       <= 1'b0;
    end else begin
      if (i_en_bus_send) begin
        if (send_pc_read) begin
          // second half of a reset, put the device back into PC_READ
          bus_out.cmd    <= PC_READ;
          last_cmd       <= PC_READ;
          o_bus_cmd_data <= 1'b0;
          o_bus_strobe   <= 1'b1;
          send_pc_read   <= 1'b0;
          ack_pending    <= 1'b1;
        end else if (send_addr) begin
          bus_out.val  <= i_address[{addr_cnt, 2'b00} +: 4];
          o_bus_strobe <= 1'b1;
          addr_cnt     <= addr_cnt + 3'd1;
          if (addr_cnt == 3'(ADDR_NIBBLES - 1)) begin
            send_addr   <= 1'b0;
            ack_pending <= 1'b1;
          end
        end else if (!o_ack) begin
          // o_ack still high means the request just closed is still on the inputs
          if (i_load_pc || i_load_dp) begin
            bus_out.cmd      <= i_load_pc ? LOAD_PC : LOAD_DP;
            last_cmd         <= i_load_pc ? LOAD_PC : LOAD_DP;
            o_bus_cmd_data   <= 1'b0;
            o_bus_strobe     <= 1'b1;
            o_stalled_by_bus <= 1'b1;
            addr_cnt         <= '0;
            send_addr        <= 1'b1;
          end else if (want_read && !i_read_stall) begin
            o_bus_strobe     <= 1'b1;
            o_stalled_by_bus <= 1'b1;
            if (last_cmd != read_cmd) begin
              bus_out.cmd    <= read_cmd;
              last_cmd       <= read_cmd;
              o_bus_cmd_data <= 1'b0;
            end else begin
              // data strobe, the device answers with the nibble
              rd_pending  <= 1'b1;
              ack_pending <= 1'b1;
            end
          end else if (i_write_dp) begin
            o_bus_strobe     <= 1'b1;
            o_stalled_by_bus <= 1'b1;
            if (last_cmd != DP_WRITE) begin
              bus_out.cmd    <= DP_WRITE;
              last_cmd       <= DP_WRITE;
              o_bus_cmd_data <= 1'b0;
            end else begin
              bus_out.val <= i_nibble;
              ack_pending <= 1'b1;
            end
          end else if (i_cmd_reset) begin
            bus_out.cmd      <= RESET;
            last_cmd         <= RESET;
            o_bus_cmd_data   <= 1'b0;
            o_bus_strobe     <= 1'b1;
            o_stalled_by_bus <= 1'b1;
            send_pc_read     <= 1'b1;
          end
        end
      end

      // bus returns to idle level after the device has sampled it
      if (i_en_bus_recv) begin
        o_bus_strobe   <= 1'b0;
        o_bus_cmd_data <= 1'b1;
      end

      // result path: close the request, loads leave the device in read mode
      if (i_en_bus_ecmd && ack_pending) begin
        ack_pending      <= 1'b0;
        rd_pending       <= 1'b0;
        o_ack            <= 1'b1;
        o_rd_valid       <= rd_pending;
        o_stalled_by_bus <= 1'b0;
        case (last_cmd)
          LOAD_PC: last_cmd <= PC_READ;
          LOAD_DP: last_cmd <= DP_READ;
          default: ;
        endcase
      end
    end
  end

  // read data from the RAM is stable by the end-of-command phase
  always_ff @(posedge i_clk) begin
    if (i_en_bus_ecmd && rd_pending) begin
      o_nibble <= i_bus_data;
    end
  end

endmodule

// File: hdl/saturn_bus_decode.sv
module saturn_bus_decode (
  input  logic                                i_clk,
  input  logic                                i_reset,
  input  logic                                i_en_bus_recv,
  input  logic [3:0]                          i_bus_data,
  input  logic                                i_bus_strobe,
  input  logic                                i_bus_cmd_data,
  output logic [saturn_bus_pkg::RAM_BITS-1:0] o_mem_addr,
  output logic                                o_mem_rd,
  output logic                                o_mem_wr,
  output logic [3:0]                          o_mem_wdata
);

  import saturn_bus_pkg::*;

  bus_nibble_u       nib;
  bus_cmd_e          mode;
  logic [ADDR_W-1:0] addr_asm;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] dp;
  logic [2:0]        nib_cnt;
  logic              nib_valid;
  logic              data_valid;
  logic              is_load;

  assign nib        = i_bus_data;
  assign nib_valid  = i_en_bus_recv && i_bus_strobe;
  assign data_valid = nib_valid && i_bus_cmd_data;
  assign is_load    = (mode == LOAD_PC) || (mode == LOAD_DP);

  // memory access happens on the receive edge itself
  assign o_mem_addr  = (mode == PC_READ) ? pc[RAM_BITS-1:0] : dp[RAM_BITS-1:0];
  assign o_mem_rd    = data_valid && ((mode == PC_READ) || (mode == DP_READ));
  assign o_mem_wr    = data_valid && (mode == DP_WRITE);
  assign o_mem_wdata = nib.val;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mode    <= PC_READ;
      pc      <= '0;
      dp      <= '0;
      nib_cnt <= '0;
    end else if (nib_valid && !i_bus_cmd_data) begin
      case (nib.cmd)
        LOAD_PC, LOAD_DP: begin
          mode    <= nib.cmd;
          nib_cnt <= '0;
        end
        PC_READ, DP_READ, DP_WRITE: mode <= nib.cmd;
        RESET: begin
          mode <= PC_READ;
          pc   <= '0;
          dp   <= '0;
        end
        default: ;
      endcase
    end else if (data_valid) begin
      if (is_load) begin
        addr_asm[{nib_cnt, 2'b00} +: 4] <= nib.val;
        nib_cnt <= nib_cnt + 3'd1;
        // last nibble goes straight into the pointer with the assembled low part
        if (nib_cnt == 3'(ADDR_NIBBLES - 1)) begin
          if (mode == LOAD_PC) begin
            pc   <= {nib.val, addr_asm[ADDR_W-5:0]};
            mode <= PC_READ;
          end else begin
            dp   <= {nib.val, addr_asm[ADDR_W-5:0]};
            mode <= DP_READ;
          end
        end
      end else if (mode == PC_READ) begin
        pc <= pc + 1'b1;
      end else if ((mode == DP_READ) || (mode == DP_WRITE)) begin
        dp <= dp + 1'b1;
      end
    end
  end

endmodule

// File: hdl/saturn_nibble_ram.sv
module saturn_nibble_ram (
  input  logic                                i_clk,
  input  logic [saturn_bus_pkg::RAM_BITS-1:0] i_addr,
  input  logic                                i_rd,
  input  logic                                i_wr,
  input  logic [3:0]                          i_wdata,
  output logic [3:0]                          o_rdata
);

  import saturn_bus_pkg::*;

  logic [3:0] mem [0:2**RAM_BITS-1];

  // registered read, a write leaves o_rdata alone
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      mem[i_addr] <= i_wdata;
    end
    if (i_rd) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

// File: hdl/saturn_bus_sys.sv
module saturn_bus_sys (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_load_pc,
  input  logic                              i_load_dp,
  input  logic                              i_read_pc,
  input  logic                              i_read_dp,
  input  logic                              i_write_dp,
  input  logic                              i_cmd_reset,
  input  logic [saturn_bus_pkg::ADDR_W-1:0] i_address,
  input  logic [3:0]                        i_nibble,
  input  logic                              i_read_stall,
  output logic [3:0]                        o_nibble,
  output logic                              o_rd_valid,
  output logic                              o_ack,
  output logic                              o_stalled_by_bus,
  output logic [3:0]                        o_bus_data,
  output logic                              o_bus_strobe,
  output logic                              o_bus_cmd_data
);

  import saturn_bus_pkg::*;

  logic                en_bus_send;
  logic                en_bus_recv;
  logic                en_bus_ecmd;
  logic [RAM_BITS-1:0] mem_addr;
  logic                mem_rd;
  logic                mem_wr;
  logic [3:0]          mem_wdata;
  logic [3:0]          mem_rdata;

  saturn_phase_gen u_phase_gen (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .o_en_bus_send (en_bus_send),
    .o_en_bus_recv (en_bus_recv),
    .o_en_bus_ecmd (en_bus_ecmd)
  );

  saturn_bus_ctrl u_bus_ctrl (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_en_bus_send    (en_bus_send),
    .i_en_bus_recv    (en_bus_recv),
    .i_en_bus_ecmd    (en_bus_ecmd),
    .i_read_stall     (i_read_stall),
    .i_load_pc        (i_load_pc),
    .i_load_dp        (i_load_dp),
    .i_read_pc        (i_read_pc),
    .i_read_dp        (i_read_dp),
    .i_write_dp       (i_write_dp),
    .i_cmd_reset      (i_cmd_reset),
    .i_address        (i_address),
    .i_nibble         (i_nibble),
    .i_bus_data       (mem_rdata),
    .o_bus_data       (o_bus_data),
    .o_bus_strobe     (o_bus_strobe),
    .o_bus_cmd_data   (o_bus_cmd_data),
    .o_nibble         (o_nibble),
    .o_rd_valid       (o_rd_valid),
    .o_ack            (o_ack),
    .o_stalled_by_bus (o_stalled_by_bus)
  );

  // device side sees the same bus lines the controller drives
  saturn_bus_decode u_bus_decode (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_en_bus_recv  (en_bus_recv),
    .i_bus_data     (o_bus_data),
    .i_bus_strobe   (o_bus_strobe),
    .i_bus_cmd_data (o_bus_cmd_data),
    .o_mem_addr     (mem_addr),
    .o_mem_rd       (mem_rd),
    .o_mem_wr       (mem_wr),
    .o_mem_wdata    (mem_wdata)
  );

  saturn_nibble_ram u_nibble_ram (
    .i_clk   (i_clk),
    .i_addr  (mem_addr),
    .i_rd    (mem_rd),
    .i_wr    (mem_wr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

// File: verif/saturn_bus_asserts.sv
module saturn_bus_asserts (
  input logic                              i_clk,
  input logic                              i_reset,
  input logic                              i_load_pc,
  input logic                              i_load_dp,
  input logic                              i_read_pc,
  input logic                              i_read_dp,
  input logic                              i_write_dp,
  input logic                              i_cmd_reset,
  input logic [saturn_bus_pkg::ADDR_W-1:0] i_address,
  input logic [3:0]                        i_nibble,
  input logic                              i_read_stall,
  input logic [3:0]                        o_nibble,
  input logic                              o_rd_valid,
  input logic                              o_ack,
  input logic                              o_stalled_by_bus,
  input logic [3:0]                        o_bus_data,
  input logic                              o_bus_strobe,
  input logic                              o_bus_cmd_data
);

  import saturn_bus_pkg::*;
  import saturn_clk_pkg::*;

  logic [3:0]          shadow_mem [0:2**RAM_BITS-1];
  logic [RAM_BITS-1:0] shadow_pc;
  logic [RAM_BITS-1:0] shadow_dp;
  bus_cmd_e            shadow_mode;
  logic [3:0]          expected_nibble;
  logic                cmd_strobe;

  int idle_fails = 0;
  int load_fails = 0;
  int hold_fails = 0;
  int ack_fails = 0;
  int stall_fails = 0;
  int mode_fails = 0;
  int reset_fails = 0;
  int read_fails = 0;

  assign expected_nibble = i_read_pc ? shadow_mem[shadow_pc] : shadow_mem[shadow_dp];
  assign cmd_strobe      = o_bus_strobe && !o_bus_cmd_data;

  // reference model, a request takes effect on the edge that samples o_ack
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      shadow_pc   <= '0;
      shadow_dp   <= '0;
      shadow_mode <= RESET;
    end else if (o_ack) begin
      if (i_load_pc) begin
        shadow_pc   <= i_address[RAM_BITS-1:0];
        shadow_mode <= PC_READ;
      end else if (i_load_dp) begin
        shadow_dp   <= i_address[RAM_BITS-1:0];
        shadow_mode <= DP_READ;
      end else if (i_read_pc) begin
        shadow_pc   <= shadow_pc + 1'b1;
        shadow_mode <= PC_READ;
      end else if (i_read_dp) begin
        shadow_dp   <= shadow_dp + 1'b1;
        shadow_mode <= DP_READ;
      end else if (i_write_dp) begin
        shadow_mem[shadow_dp] <= i_nibble;
        shadow_dp             <= shadow_dp + 1'b1;
        shadow_mode           <= DP_WRITE;
      end else if (i_cmd_reset) begin
        shadow_pc   <= '0;
        shadow_dp   <= '0;
        shadow_mode <= PC_READ;
      end
    end
  end

  idle_after_reset: assert property (@(posedge i_clk)
    i_reset |=> !o_bus_strobe && !o_ack && !o_rd_valid && !o_stalled_by_bus && o_bus_cmd_data)
    else begin
      idle_fails++;
      $error("bus outputs are not idle after reset");
    end

  // five address nibbles, least significant first, one per bus cycle
  load_address: assert property (@(posedge i_clk) disable iff (i_reset)
    (cmd_strobe && (o_bus_data inside {LOAD_PC, LOAD_DP}))
    |-> ##BUS_PHASES (o_bus_strobe && o_bus_cmd_data && o_bus_data == i_address[3:0])
        ##BUS_PHASES (o_bus_strobe && o_bus_cmd_data && o_bus_data == i_address[7:4])
        ##BUS_PHASES (o_bus_strobe && o_bus_cmd_data && o_bus_data == i_address[11:8])
        ##BUS_PHASES (o_bus_strobe && o_bus_cmd_data && o_bus_data == i_address[15:12])
        ##BUS_PHASES (o_bus_strobe && o_bus_cmd_data && o_bus_data == i_address[19:16]))
    else begin
      load_fails++;
      $error("load command was not followed by the five address nibbles");
    end

  stalled_until_ack: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_stalled_by_bus && !o_ack) |=> (o_stalled_by_bus || o_ack))
    else begin
      hold_fails++;
      $error("o_stalled_by_bus dropped before o_ack");
    end

  // o_ack only closes an accepted request and o_rd_valid marks exactly the reads
  ack_closes_request: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_ack || o_rd_valid)
    |-> (o_ack && $past(o_stalled_by_bus) && (o_rd_valid == (i_read_pc || i_read_dp))))
    else begin
      ack_fails++;
      $error("o_ack without a request in flight or o_rd_valid not paired with a read ack");
    end

  read_waits_on_stall: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_read_stall && (i_read_pc || i_read_dp) && !o_stalled_by_bus)
    |=> (!o_bus_strobe && !o_ack))
    else begin
      stall_fails++;
      $error("a read went onto the bus while i_read_stall was high");
    end

  // mode commands only when the device mode has to change
  mode_on_change: assert property (@(posedge i_clk) disable iff (i_reset)
    (cmd_strobe && !i_cmd_reset && (o_bus_data inside {PC_READ, DP_READ, DP_WRITE}))
    |-> (o_bus_data != shadow_mode))
    else begin
      mode_fails++;
      $error("mode command sent although the mode did not change");
    end

  reset_then_pc_read: assert property (@(posedge i_clk) disable iff (i_reset)
    (cmd_strobe && o_bus_data == RESET)
    |-> ##BUS_PHASES (cmd_strobe && o_bus_data == PC_READ))
    else begin
      reset_fails++;
      $error("RESET command was not followed by PC_READ");
    end

  read_data: assert property (@(posedge i_clk) disable iff (i_reset)
    o_rd_valid |-> (o_nibble == expected_nibble))
    else begin
      read_fails++;
      $error("Fail t=%0t o_nibble expected %h got %h",
             $time, $sampled(expected_nibble), $sampled(o_nibble));
    end

endmodule

bind saturn_bus_sys saturn_bus_asserts u_saturn_bus_asserts (.*);

// File: verif/saturn_bus_tb.sv
module saturn_bus_tb;

  import saturn_bus_pkg::*;
  import saturn_clk_pkg::*;

  localparam int REQ_LOAD_PC  = 0;
  localparam int REQ_LOAD_DP  = 1;
  localparam int REQ_READ_PC  = 2;
  localparam int REQ_READ_DP  = 3;
  localparam int REQ_WRITE_DP = 4;
  localparam int REQ_RESET    = 5;

  // request counts of the sequence below
  localparam int NUM_LOADS    = 10;
  localparam int NUM_SHORT    = 36;
  localparam int STALL_CYCLES = 3 * BUS_PHASES;
  localparam int CYCLE_LIMIT  =
    ((NUM_SHORT * 2 + NUM_LOADS * 6) * BUS_PHASES + STALL_CYCLES + 3) * 3 / 2;

  logic              i_clk;
  logic              i_reset;
  logic              i_load_pc;
  logic              i_load_dp;
  logic              i_read_pc;
  logic              i_read_dp;
  logic              i_write_dp;
  logic              i_cmd_reset;
  logic [ADDR_W-1:0] i_address;
  logic [3:0]        i_nibble;
  logic              i_read_stall;
  logic [3:0]        o_nibble;
  logic              o_rd_valid;
  logic              o_ack;
  logic              o_stalled_by_bus;
  logic [3:0]        o_bus_data;
  logic              o_bus_strobe;
  logic              o_bus_cmd_data;
  integer            seed;
  int                cycles = 0;

  saturn_bus_sys u_saturn_bus_sys (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_load_pc        (i_load_pc),
    .i_load_dp        (i_load_dp),
    .i_read_pc        (i_read_pc),
    .i_read_dp        (i_read_dp),
    .i_write_dp       (i_write_dp),
    .i_cmd_reset      (i_cmd_reset),
    .i_address        (i_address),
    .i_nibble         (i_nibble),
    .i_read_stall     (i_read_stall),
    .o_nibble         (o_nibble),
    .o_rd_valid       (o_rd_valid),
    .o_ack            (o_ack),
    .o_stalled_by_bus (o_stalled_by_bus),
    .o_bus_data       (o_bus_data),
    .o_bus_strobe     (o_bus_strobe),
    .o_bus_cmd_data   (o_bus_cmd_data)
  );

  always begin
    #20;
    i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a request was never acknowledged", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [ADDR_W-1:0] random_base();
    logic [ADDR_W-1:0] value;
    value = ADDR_W'($random(seed));
    return value & ADDR_W'(2**RAM_BITS - 1);
  endfunction

  task automatic drop_requests();
    i_load_pc   = 1'b0;
    i_load_dp   = 1'b0;
    i_read_pc   = 1'b0;
    i_read_dp   = 1'b0;
    i_write_dp  = 1'b0;
    i_cmd_reset = 1'b0;
  endtask

  // hold the request through the edge that samples o_ack
  task automatic wait_for_ack();
    do begin
      @(negedge i_clk);
    end while (!o_ack);
    @(negedge i_clk);
  endtask

  task automatic run_request(input int kind, input logic [ADDR_W-1:0] addr,
                             input logic [3:0] data);
    @(negedge i_clk);
    i_address = addr;
    i_nibble  = data;
    case (kind)
      REQ_LOAD_PC:  i_load_pc  = 1'b1;
      REQ_LOAD_DP:  i_load_dp  = 1'b1;
      REQ_READ_PC:  i_read_pc  = 1'b1;
      REQ_READ_DP:  i_read_dp  = 1'b1;
      REQ_WRITE_DP: i_write_dp = 1'b1;
      default:      i_cmd_reset = 1'b1;
    endcase
    wait_for_ack();
    drop_requests();
  endtask

  task automatic run_stalled_read(input int stall_cycles);
    @(negedge i_clk);
    i_read_stall = 1'b1;
    i_read_pc    = 1'b1;
    repeat (stall_cycles) @(negedge i_clk);
    i_read_stall = 1'b0;
    wait_for_ack();
    drop_requests();
  endtask

  // four nibbles written through DP, read back through DP and then PC
  task automatic write_then_read(input logic [ADDR_W-1:0] base);
    run_request(REQ_LOAD_DP, base, 4'h0);
    repeat (4) run_request(REQ_WRITE_DP, base, 4'($random(seed)));
    run_request(REQ_LOAD_DP, base, 4'h0);
    repeat (4) run_request(REQ_READ_DP, base, 4'h0);
    run_request(REQ_LOAD_PC, base, 4'h0);
    repeat (4) run_request(REQ_READ_PC, base, 4'h0);
  endtask

  initial begin
    logic [ADDR_W-1:0] base;
    int                fails;
    seed         = 65;
    i_clk        = 1'b0;
    i_reset      = 1'b1;
    i_address    = '0;
    i_nibble     = 4'h0;
    i_read_stall = 1'b0;
    drop_requests();
    repeat (3) @(negedge i_clk);
    i_reset = 1'b0;

    repeat (2) begin
      base = random_base();
      write_then_read(base);
    end

    // alternating pointers forces a mode command on each read after the first
    run_request(REQ_LOAD_DP, base, 4'h0);
    run_request(REQ_LOAD_PC, base, 4'h0);
    repeat (4) begin
      run_request(REQ_READ_PC, base, 4'h0);
      run_request(REQ_READ_DP, base, 4'h0);
    end

    run_request(REQ_LOAD_PC, base, 4'h0);
    run_stalled_read(STALL_CYCLES);

    // bus reset leaves PC at address 0
    run_request(REQ_LOAD_DP, '0, 4'h0);
    run_request(REQ_WRITE_DP, '0, 4'($random(seed)));
    run_request(REQ_RESET, '0, 4'h0);
    run_request(REQ_READ_PC, '0, 4'h0);

    repeat (2 * BUS_PHASES) @(negedge i_clk);
    fails = u_saturn_bus_sys.u_saturn_bus_asserts.idle_fails
          + u_saturn_bus_sys.u_saturn_bus_asserts.load_fails
          + u_saturn_bus_sys.u_saturn_bus_asserts.hold_fails
          + u_saturn_bus_sys.u_saturn_bus_asserts.ack_fails
          + u_saturn_bus_sys.u_saturn_bus_asserts.stall_fails
          + u_saturn_bus_sys.u_saturn_bus_asserts.mode_fails
          + u_saturn_bus_sys.u_saturn_bus_asserts.reset_fails
          + u_saturn_bus_sys.u_saturn_bus_asserts.read_fails;
    $display({"errors %0d: idle %0d load %0d hold %0d ack %0d stall %0d mode %0d",
              " reset %0d read %0d"},
             fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.idle_fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.load_fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.hold_fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.ack_fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.stall_fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.mode_fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.reset_fails,
             u_saturn_bus_sys.u_saturn_bus_asserts.read_fails);
    if (fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: saturn_bus.f
hdl/saturn_clk_pkg.sv
hdl/saturn_bus_pkg.sv
hdl/saturn_phase_gen.sv
hdl/saturn_bus_ctrl.sv
hdl/saturn_bus_decode.sv
hdl/saturn_nibble_ram.sv
hdl/saturn_bus_sys.sv
verif/saturn_bus_asserts.sv
verif/saturn_bus_tb.sv

// File: Makefile
SIM  := obj_dir/saturn_bus_sim
SRCS := $(shell cat saturn_bus.f)

.PHONY: all run clean

all: run

$(SIM): saturn_bus.f $(SRCS)
	verilator --binary --timing --assert -f saturn_bus.f \
	  --top-module saturn_bus_tb -Mdir obj_dir -o saturn_bus_sim

# failing assertions must not end the run before the closing line
run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" sim.log; then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
